/* Makefile */
# Verilator build of the UART testbench

SOURCES = uartPkg.sv baudTimer.sv uartRx.sv uartTx.sv uartIo.sv uartIoTb.sv

.PHONY: all run clean

all: obj_dir/VuartIoTb

# rebuilt only when a source or the file list changes
obj_dir/VuartIoTb: sim.f $(SOURCES)
	verilator --binary --timing --assert --top-module uartIoTb -f sim.f

# pass only when the pass line shows up in the output
run: obj_dir/VuartIoTb
	@out="$$(./obj_dir/VuartIoTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* baudTimer.sv */
/*
 * Bit-period counter for the UART.
 * A restart zeroes the count. While run is high it counts through one bit
 * period of clksPerBit clocks and strobes at the middle and at the end.
 */

`timescale 1ns/1ps

module baudTimer #(
	parameter int clksPerBit = 217
) (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic restart,
	output logic midBit,
	output logic endBit
);

	localparam int cntW = $clog2(clksPerBit);
	localparam logic [cntW-1:0] midCount = cntW'(clksPerBit / 2);
	localparam logic [cntW-1:0] lastCount = cntW'(clksPerBit - 1);

	logic [cntW-1:0] count;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;
		end else if (run) begin
			// wrap on the last clock of the bit
			if (count == lastCount) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// strobes only while the owner is in a frame
	assign midBit = run && (count == midCount);
	assign endBit = run && (count == lastCount);

endmodule

/* sim.f */
uartPkg.sv
baudTimer.sv
uartRx.sv
uartTx.sv
uartIo.sv
uartIoTb.sv

/* uartIo.sv */
/*
 * Top level of the word-level UART.
 * Joins the receiver and the transmitter and hands both the same
 * bit period. Software reads rxWord and txWord as 16-bit status words.
 */

`timescale 1ns/1ps

module uartIo #(
	// 217 gives 115200 baud from 25 MHz
	parameter int clksPerBit = 217
) (
	input  logic clk,
	input  logic arstN,
	input  logic rxLine,
	input  logic rxClear,
	output logic [uartPkg::statusBit:0] rxWord,
	input  logic txLoad,
	input  logic [7:0] txByte,
	output logic txLine,
	output logic [uartPkg::statusBit:0] txWord
);

	// receive path, serial in to status word
	uartRx #(
		.clksPerBit(clksPerBit)
	) uartRx_inst (
		.clk(clk),
		.arstN(arstN),
		.rxLine(rxLine),
		.rxClear(rxClear),
		.rxWord(rxWord)
	);

	// transmit path, byte in to serial out
	uartTx #(
		.clksPerBit(clksPerBit)
	) uartTx_inst (
		.clk(clk),
		.arstN(arstN),
		.txLoad(txLoad),
		.txByte(txByte),
		.txLine(txLine),
		.txWord(txWord)
	);

endmodule

/* uartIoTb.sv */
/*
 * Self-checking testbench for the word-level UART top level.
 * Drives serial frames into the receiver, samples the transmitter line,
 * and closes the loop from txLine to rxLine. Run it through sim.f.
 */

`timescale 1ns/1ps

module uartIoTb;

	localparam int bitClks = 16;
	localparam int frameClks = 10 * bitClks;
	localparam int glitchClks = 4;
	// transmit, four receive, three line error frames, loopback, spare
	localparam int numFrames = 10;
	localparam int watchdogClks = 2 * numFrames * frameClks + 1000;

	logic clk;
	logic arstN;
	logic rxDrive;
	logic loopback;
	logic rxLineIn;
	logic rxClear;
	logic [15:0] rxWord;
	logic txLoad;
	logic [7:0] txByte;
	logic txLine;
	logic [15:0] txWord;

	logic [31:0] lfsrState;
	string testName;
	int testErrors;
	int passCount;
	int failCount;

	// loopback mode feeds the transmitter straight into the receiver
	assign rxLineIn = loopback ? txLine : rxDrive;

	uartIo #(
		.clksPerBit(bitClks)
	) uartIo_inst (
		.clk(clk),
		.arstN(arstN),
		.rxLine(rxLineIn),
		.rxClear(rxClear),
		.rxWord(rxWord),
		.txLoad(txLoad),
		.txByte(txByte),
		.txLine(txLine),
		.txWord(txWord)
	);

	always #4 clk = ~clk;

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	task automatic randomByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			b[i] = lfsrState[0];
		end
	endtask

	// lands 1 ns after the n-th rising edge from now
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic checkValue(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s (%s): expected %h, actual %h",
				testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic finishTest();
		if (testErrors == 0) begin
			passCount++;
			$display("test %s passed", testName);
		end else begin
			failCount++;
			$display("test %s failed with %0d errors", testName, testErrors);
		end
	endtask

	// 8N1 frame on rxLine, lsb first; glitch sends only a short low pulse
	task automatic driveFrame(input logic [7:0] data, input bit glitch, input bit badStop);
		logic [9:0] frame;
		frame = {~badStop, data, 1'b0};
		if (glitch) begin
			rxDrive = 1'b0;
			waitCycles(glitchClks);
		end else begin
			for (int i = 0; i < 10; i++) begin
				rxDrive = frame[i];
				waitCycles(bitClks);
			end
		end
		rxDrive = 1'b1;
	endtask

	task automatic pulseClear();
		rxClear = 1'b1;
		waitCycles(1);
		rxClear = 1'b0;
	endtask

	initial begin
		repeat (watchdogClks) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", watchdogClks);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [7:0] sent;
		logic [9:0] seen;
		int waitLen;
		clk = 1'b0;
		arstN = 1'b0;
		rxDrive = 1'b1;
		loopback = 1'b0;
		rxClear = 1'b0;
		txLoad = 1'b0;
		txByte = 8'h00;
		lfsrState = 32'he5792a46;
		passCount = 0;
		failCount = 0;
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;

		startTest("reset");
		checkValue("rxWord", 16'h8000, rxWord);
		checkValue("txWord", 16'h0000, txWord);
		checkValue("txLine", 16'h0001, 16'(txLine));
		finishTest();

		startTest("transmit");
		randomByte(sent);
		txByte = sent;
		txLoad = 1'b1;
		waitCycles(1);
		txLoad = 1'b0;
		// sample each bit in its middle, the load pulse costs one cycle
		for (int i = 0; i < 10; i++) begin
			waitLen = (i == 0) ? bitClks / 2 : ((i == 1) ? bitClks - 1 : bitClks);
			waitCycles(waitLen);
			seen[i] = txLine;
			checkValue("busy in frame", 16'h0001, 16'(txWord[15]));
			checkValue("held byte", 16'(sent), 16'(txWord[7:0]));
			if (i == 0) begin
				// must be dropped while busy
				txByte = ~sent;
				txLoad = 1'b1;
				waitCycles(1);
				txLoad = 1'b0;
			end
		end
		checkValue("frame bits", 16'({1'b1, sent, 1'b0}), 16'(seen));
		waitCycles(bitClks / 2 - 1);
		checkValue("busy last cycle", 16'h0001, 16'(txWord[15]));
		waitCycles(1);
		checkValue("idle after frame", 16'h0000, 16'(txWord[15]));
		checkValue("byte after frame", 16'(sent), 16'(txWord[7:0]));
		finishTest();

		// back to back, each byte replaces the last
		startTest("receive");
		for (int i = 0; i < 4; i++) begin
			randomByte(sent);
			driveFrame(sent, 1'b0, 1'b0);
			checkValue("received word", {8'h00, sent}, rxWord);
		end
		finishTest();

		startTest("clear");
		pulseClear();
		checkValue("after clear", 16'h8000, rxWord);
		waitCycles(2 * bitClks);
		checkValue("idle after clear", 16'h8000, rxWord);
		finishTest();

		startTest("line errors");
		pulseClear();
		driveFrame(8'h00, 1'b1, 1'b0);
		// a false start would have run a whole frame and committed by now
		waitCycles(frameClks + 2 * bitClks);
		checkValue("after glitch", 16'h8000, rxWord);
		randomByte(sent);
		driveFrame(sent, 1'b0, 1'b1);
		waitCycles(3 * bitClks);
		checkValue("after bad stop", 16'h8000, rxWord);
		randomByte(sent);
		driveFrame(sent, 1'b0, 1'b0);
		checkValue("good frame", {8'h00, sent}, rxWord);
		finishTest();

		startTest("loopback");
		loopback = 1'b1;
		pulseClear();
		randomByte(sent);
		txByte = sent;
		txLoad = 1'b1;
		waitCycles(1);
		txLoad = 1'b0;
		// wait for the receiver to report a byte
		for (int i = 0; i < 12 * bitClks && rxWord[15]; i++) begin
			waitCycles(1);
		end
		assert (!rxWord[15]) else begin
			$display("in %s no byte arrived at the receiver in time", testName);
			testErrors++;
		end
		checkValue("looped word", {8'h00, sent}, rxWord);
		finishTest();

		$display("tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* uartPkg.sv */
/*
 * Shared definitions for the word-level UART.
 * Holds the receive and transmit state encodings and the 8N1 frame
 * constants. Modules import it inside their body and use scoped names
 * for port widths.
 */

package uartPkg;

	// data bits per frame, sent lsb first
	localparam int dataBits = 8;

	// index of the flag bit in a 16-bit status word
	localparam int statusBit = 15;

	// receiver FSM
	// idle waits for a falling edge, start checks the start bit midpoint,
	// data collects the byte, stop checks the stop bit and commits
	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState;

	// transmitter FSM
	// one state per part of the frame, idle keeps the line high
	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txState;

endpackage

/* uartRx.sv */
/*
 * UART receiver with a 16-bit status word.
 * rxClear empties the word and sets the flag bit, meaning ready with no byte.
 * A received 8N1 byte shows up in bits 7..0 with the flag at 0 and stays
 * until the next byte or the next clear.
 */

`timescale 1ns/1ps

module uartRx #(
	parameter int clksPerBit = 217
) (
	input  logic clk,
	input  logic arstN,
	input  logic rxLine,
	input  logic rxClear,
	output logic [uartPkg::statusBit:0] rxWord
);

	import uartPkg::*;

	// bit index counts samples taken, so it must reach dataBits
	localparam int idxW = $clog2(dataBits + 1);
	localparam logic [statusBit:0] emptyWord = {1'b1, {statusBit{1'b0}}};

	rxState state;
	logic rxMeta;
	logic rxSync;
	logic [idxW-1:0] bitIdx;
	logic [dataBits-1:0] shiftReg;
	logic timerRun;
	logic timerRestart;
	logic midBit;
	logic endBit;
	logic byteDone;

	// two-flop synchronizer, idles high like the line
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= rxLine;
			rxSync <= rxMeta;
		end
	end

	// timer runs for the whole frame and restarts on the falling edge
	assign timerRun = (state != rxIdle);
	assign timerRestart = (state == rxIdle) && !rxSync;

	baudTimer #(
		.clksPerBit(clksPerBit)
	) baudTimer_inst (
		.clk(clk),
		.arstN(arstN),
		.run(timerRun),
		.restart(timerRestart),
		.midBit(midBit),
		.endBit(endBit)
	);

	// valid stop bit at its midpoint
	assign byteDone = (state == rxStop) && midBit && rxSync;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= rxIdle;
			bitIdx <= '0;
		end else begin
			unique case (state)
				rxIdle: begin
					bitIdx <= '0;
					if (!rxSync) state <= rxStart;
				end
				rxStart: begin
					// line back high at midpoint means a glitch
					if (midBit) state <= rxSync ? rxIdle : rxData;
				end
				rxData: begin
					if (midBit) bitIdx <= bitIdx + 1'b1;
					// first endBit here closes the start bit, index still 0
					if (endBit && bitIdx == idxW'(dataBits)) state <= rxStop;
				end
				rxStop: begin
					// leave at midpoint so the next falling edge is caught
					if (midBit) state <= rxIdle;
				end
			endcase
		end
	end

	// data bits enter at the top, lsb ends up in bit 0
	always_ff @(posedge clk) begin
		if (state == rxData && midBit) begin
			shiftReg <= {rxSync, shiftReg[dataBits-1:1]};
		end
	end

	// a completed byte beats a clear in the same cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rxWord <= emptyWord;
		end else if (byteDone) begin
			rxWord <= {1'b0, {(statusBit - dataBits){1'b0}}, shiftReg};
		end else if (rxClear) begin
			rxWord <= emptyWord;
		end
	end

endmodule

/* uartTx.sv */
/*
 * UART transmitter with a 16-bit status word.
 * A txLoad strobe while idle sends txByte as one 8N1 frame. Bit 15 of txWord
 * is high while the frame is on the line, bits 7..0 hold the last loaded byte.
 * Loads during a frame are dropped.
 */

`timescale 1ns/1ps

module uartTx #(
	parameter int clksPerBit = 217
) (
	input  logic clk,
	input  logic arstN,
	input  logic txLoad,
	input  logic [7:0] txByte,
	output logic txLine,
	output logic [uartPkg::statusBit:0] txWord
);

	import uartPkg::*;

	localparam int idxW = $clog2(dataBits);

	txState state;
	logic [idxW-1:0] bitIdx;
	logic [dataBits-1:0] shiftReg;
	logic [dataBits-1:0] txHold;
	logic accept;
	logic endBit;

	assign accept = txLoad && (state == txIdle);

	// transmitter only needs bit ends, the midpoint strobe is left open
	baudTimer #(
		.clksPerBit(clksPerBit)
	) baudTimer_inst (
		.clk(clk),
		.arstN(arstN),
		.run(state != txIdle),
		.restart(accept),
		.midBit(),
		.endBit(endBit)
	);

	// line is driven from a flop so it never glitches
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= txIdle;
			bitIdx <= '0;
			txLine <= 1'b1;
			txHold <= '0;
		end else begin
			unique case (state)
				txIdle: begin
					if (accept) begin
						txHold <= txByte;
						bitIdx <= '0;
						txLine <= 1'b0;
						state <= txStart;
					end
				end
				txStart: begin
					if (endBit) begin
						txLine <= shiftReg[0];
						state <= txData;
					end
				end
				txData: begin
					if (endBit) begin
						if (bitIdx == idxW'(dataBits - 1)) begin
							txLine <= 1'b1;
							state <= txStop;
						end else begin
							txLine <= shiftReg[0];
							bitIdx <= bitIdx + 1'b1;
						end
					end
				end
				txStop: begin
					// busy drops right after the last stop bit clock
					if (endBit) state <= txIdle;
				end
			endcase
		end
	end

	// shift out lsb first, bit 0 is always the next bit to send
	always_ff @(posedge clk) begin
		if (accept) begin
			shiftReg <= txByte;
		end else if (endBit && (state == txStart || state == txData)) begin
			shiftReg <= shiftReg >> 1;
		end
	end

	assign txWord = {state != txIdle, {(statusBit - dataBits){1'b0}}, txHold};

endmodule
